// File: rtl/mul_pkg.sv
package mul_pkg;

  localparam int XLEN    = 32;
  localparam int PROD_W  = 64;
  localparam int DIGITS  = 16;
  localparam int RD_W    = 5;
  localparam int LATENCY = 6;

  // word counts after the first two reduction levels
  localparam int RED8_N = DIGITS / 2;
  localparam int RED4_N = DIGITS / 4;

  // 2'b10 (mulhsu) is not supported
  typedef enum logic [1:0] {
    OP_MUL   = 2'b00,
    OP_MULH  = 2'b01,
    OP_MULHU = 2'b11
  } mul_op_t;

  // all flags clear encodes a zero digit
  typedef struct packed {
    logic neg;
    logic one;
    logic two;
  } booth_digit_t;

  typedef struct packed {
    logic [XLEN-1:0]                a;
    booth_digit_t [DIGITS-1:0]      digits;
    logic                           b_top;
  } enc_payload_t;

  typedef struct packed {
    logic [DIGITS-1:0][PROD_W-1:0]  pp;
    logic [PROD_W-1:0]              corr;
  } pp_payload_t;

  typedef struct packed {
    logic [RED8_N-1:0][PROD_W-1:0]  w;
    logic [PROD_W-1:0]              corr;
  } red8_payload_t;

  typedef struct packed {
    logic [RED4_N-1:0][PROD_W-1:0]  w;
    logic [PROD_W-1:0]              corr;
  } red4_payload_t;

  typedef struct packed {
    logic [PROD_W-1:0] sum;
    logic [PROD_W-1:0] carry;
    logic [PROD_W-1:0] corr;
  } red2_payload_t;

endpackage

// File: rtl/mul_stage_if.sv
interface mul_stage_if #(
  parameter type payload_t = logic
) ();

  logic                     valid;
  mul_pkg::mul_op_t         op;
  logic [mul_pkg::RD_W-1:0] rd;
  payload_t                 data;

  modport src (
    output valid,
    output op,
    output rd,
    output data
  );

  modport dst (
    input valid,
    input op,
    input rd,
    input data
  );

endinterface

// File: rtl/mul_stage_reg.sv
module mul_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic                     Clk,
  input  logic                     Reset,
  input  logic                     valid,
  input  mul_pkg::mul_op_t         op,
  input  logic [mul_pkg::RD_W-1:0] rd,
  input  payload_t                 data,
  mul_stage_if.src                 out_if
);

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      out_if.valid <= 1'b0;
      out_if.op    <= mul_pkg::OP_MUL;
      out_if.rd    <= '0;
    end else begin
      out_if.valid <= valid;
      if (valid) begin
        out_if.op <= op;
        out_if.rd <= rd;
      end
    end
  end

  // payload only moves with a live item
  always_ff @(posedge Clk) begin
    if (valid) begin
      out_if.data <= data;
    end
  end

  // an unknown valid would corrupt every later stage
  valid_known_a: assert property (@(posedge Clk) disable iff (Reset)
    !$isunknown(out_if.valid))
    else $error("stage valid is unknown");

endmodule

// File: rtl/csa_reduce.sv
module csa_reduce (
  input  logic [mul_pkg::PROD_W-1:0] w0,
  input  logic [mul_pkg::PROD_W-1:0] w1,
  input  logic [mul_pkg::PROD_W-1:0] w2,
  input  logic [mul_pkg::PROD_W-1:0] w3,
  output logic [mul_pkg::PROD_W-1:0] sum,
  output logic [mul_pkg::PROD_W-1:0] carry
);

  logic [mul_pkg::PROD_W-1:0] s1;
  logic [mul_pkg::PROD_W-1:0] c1;

  // first row of 3:2 counters
  assign s1 = w0 ^ w1 ^ w2;
  assign c1 = ((w0 & w1) | (w0 & w2) | (w1 & w2)) << 1;

  // second row folds in the fourth word
  assign sum   = s1 ^ c1 ^ w3;
  assign carry = ((s1 & c1) | (s1 & w3) | (c1 & w3)) << 1;

endmodule

// File: rtl/booth_encoder.sv
module booth_encoder (
  input  logic                     Clk,
  input  logic                     Reset,
  input  logic                     start,
  input  mul_pkg::mul_op_t         op,
  input  logic [mul_pkg::XLEN-1:0] a,
  input  logic [mul_pkg::XLEN-1:0] b,
  input  logic [mul_pkg::RD_W-1:0] rd,
  mul_stage_if.src                 out_if
);

  // implied zero below bit 0
  logic [mul_pkg::XLEN:0]                    b_ext;
  mul_pkg::booth_digit_t [mul_pkg::DIGITS-1:0] digits;
  mul_pkg::enc_payload_t                     enc_d;

  assign b_ext = {b, 1'b0};

  for (genvar i = 0; i < mul_pkg::DIGITS; i++) begin : g_digit
    logic [2:0] trip;

    assign trip = b_ext[2*i +: 3];
    // 111 is a zero digit, so keep neg clear there
    assign digits[i].neg = trip[2] & ~(trip[1] & trip[0]);
    assign digits[i].one = trip[1] ^ trip[0];
    assign digits[i].two = (trip[2] & ~trip[1] & ~trip[0]) |
                           (~trip[2] & trip[1] & trip[0]);
  end

  assign enc_d = {a, digits, b[mul_pkg::XLEN-1]};

  mul_stage_reg #(
    .payload_t (mul_pkg::enc_payload_t)
  ) u_enc_reg (
    .Clk    (Clk),
    .Reset  (Reset),
    .valid  (start),
    .op     (op),
    .rd     (rd),
    .data   (enc_d),
    .out_if (out_if)
  );

  // mulhsu encoding has no datapath behind it
  no_mulhsu_a: assert property (@(posedge Clk) disable iff (Reset)
    start |-> (op != 2'b10))
    else $error("start issued with unsupported op 2'b10");

endmodule

// File: rtl/pp_generator.sv
module pp_generator (
  input  logic     Clk,
  input  logic     Reset,
  mul_stage_if.dst in_if,
  mul_stage_if.src out_if
);

  logic [mul_pkg::PROD_W-1:0] a_ext;
  logic [mul_pkg::PROD_W-1:0] mag;
  mul_pkg::booth_digit_t      dig;
  logic                       unsigned_op;
  mul_pkg::pp_payload_t       pp_d;

  assign unsigned_op = (in_if.op == mul_pkg::OP_MULHU);

  always_comb begin
    // mulhu sees a as unsigned, the signed ops sign-extend it
    if (unsigned_op) begin
      a_ext = {{(mul_pkg::PROD_W - mul_pkg::XLEN){1'b0}}, in_if.data.a};
    end else begin
      a_ext = {{(mul_pkg::PROD_W - mul_pkg::XLEN){in_if.data.a[mul_pkg::XLEN-1]}},
               in_if.data.a};
    end

    dig = '0;
    mag = '0;
    for (int i = 0; i < mul_pkg::DIGITS; i++) begin
      dig = in_if.data.digits[i];
      if (dig.two) begin
        mag = a_ext << 1;
      end else if (dig.one) begin
        mag = a_ext;
      end else begin
        mag = '0;
      end
      if (dig.neg) begin
        mag = ~mag + {{(mul_pkg::PROD_W - 1){1'b0}}, 1'b1};
      end
      pp_d.pp[i] = mag << (2 * i);
    end

    // booth treats b as signed, so add back a * 2^32 when b[31] was set
    if (unsigned_op && in_if.data.b_top) begin
      pp_d.corr = {in_if.data.a, {mul_pkg::XLEN{1'b0}}};
    end else begin
      pp_d.corr = '0;
    end
  end

  mul_stage_reg #(
    .payload_t (mul_pkg::pp_payload_t)
  ) u_pp_reg (
    .Clk    (Clk),
    .Reset  (Reset),
    .valid  (in_if.valid),
    .op     (in_if.op),
    .rd     (in_if.rd),
    .data   (pp_d),
    .out_if (out_if)
  );

endmodule

// File: rtl/reduction_tree.sv
module reduction_tree (
  input  logic     Clk,
  input  logic     Reset,
  mul_stage_if.dst in_if,
  mul_stage_if.src out_if
);

  localparam int GROUPS = mul_pkg::DIGITS / 4;

  mul_stage_if #(.payload_t(mul_pkg::red8_payload_t)) r8_if ();
  mul_stage_if #(.payload_t(mul_pkg::red4_payload_t)) r4_if ();

  logic [mul_pkg::PROD_W-1:0] s3_sum   [GROUPS];
  logic [mul_pkg::PROD_W-1:0] s3_carry [GROUPS];
  logic [mul_pkg::PROD_W-1:0] s5_sum;
  logic [mul_pkg::PROD_W-1:0] s5_carry;
  mul_pkg::red8_payload_t     r8_d;
  mul_pkg::red4_payload_t     r4_d;
  mul_pkg::red2_payload_t     r2_d;

  // stage three, each group of four partial products to a pair
  for (genvar k = 0; k < GROUPS; k++) begin : g_s3
    csa_reduce u_csa (
      .w0    (in_if.data.pp[4*k]),
      .w1    (in_if.data.pp[4*k+1]),
      .w2    (in_if.data.pp[4*k+2]),
      .w3    (in_if.data.pp[4*k+3]),
      .sum   (s3_sum[k]),
      .carry (s3_carry[k])
    );
  end

  always_comb begin
    for (int k = 0; k < GROUPS; k++) begin
      r8_d.w[2*k]   = s3_sum[k];
      r8_d.w[2*k+1] = s3_carry[k];
    end
    r8_d.corr = in_if.data.corr;
  end

  mul_stage_reg #(
    .payload_t (mul_pkg::red8_payload_t)
  ) u_r8_reg (
    .Clk    (Clk),
    .Reset  (Reset),
    .valid  (in_if.valid),
    .op     (in_if.op),
    .rd     (in_if.rd),
    .data   (r8_d),
    .out_if (r8_if)
  );

  // stage four, sum and carry of each pair resolved
  always_comb begin
    for (int k = 0; k < mul_pkg::RED4_N; k++) begin
      r4_d.w[k] = r8_if.data.w[2*k] + r8_if.data.w[2*k+1];
    end
    r4_d.corr = r8_if.data.corr;
  end

  mul_stage_reg #(
    .payload_t (mul_pkg::red4_payload_t)
  ) u_r4_reg (
    .Clk    (Clk),
    .Reset  (Reset),
    .valid  (r8_if.valid),
    .op     (r8_if.op),
    .rd     (r8_if.rd),
    .data   (r4_d),
    .out_if (r4_if)
  );

  // stage five
  csa_reduce u_csa_last (
    .w0    (r4_if.data.w[0]),
    .w1    (r4_if.data.w[1]),
    .w2    (r4_if.data.w[2]),
    .w3    (r4_if.data.w[3]),
    .sum   (s5_sum),
    .carry (s5_carry)
  );

  assign r2_d = {s5_sum, s5_carry, r4_if.data.corr};

  mul_stage_reg #(
    .payload_t (mul_pkg::red2_payload_t)
  ) u_r2_reg (
    .Clk    (Clk),
    .Reset  (Reset),
    .valid  (r4_if.valid),
    .op     (r4_if.op),
    .rd     (r4_if.rd),
    .data   (r2_d),
    .out_if (out_if)
  );

endmodule

// File: rtl/final_adder.sv
module final_adder (
  input  logic                     Clk,
  input  logic                     Reset,
  mul_stage_if.dst                 in_if,
  output logic                     done,
  output logic [mul_pkg::RD_W-1:0] rd_out,
  output logic [mul_pkg::XLEN-1:0] result
);

  logic [mul_pkg::PROD_W-1:0] product;
  logic [mul_pkg::XLEN-1:0]   half;

  // carry-propagate add, correction only nonzero for mulhu
  assign product = in_if.data.sum + in_if.data.carry + in_if.data.corr;

  always_comb begin
    if (in_if.op == mul_pkg::OP_MUL) begin
      half = product[mul_pkg::XLEN-1:0];
    end else begin
      half = product[mul_pkg::PROD_W-1:mul_pkg::XLEN];
    end
  end

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      done   <= 1'b0;
      rd_out <= '0;
      result <= '0;
    end else begin
      done <= in_if.valid;
      // outputs hold between items
      if (in_if.valid) begin
        rd_out <= in_if.rd;
        result <= half;
      end
    end
  end

  // a finished item must carry a known tag and result
  done_known_a: assert property (@(posedge Clk) disable iff (Reset)
    done |-> !$isunknown({rd_out, result}))
    else $error("done pulsed with an unknown tag or result");

endmodule

// File: rtl/booth_mul.sv
module booth_mul (
  input  logic                     Clk,
  input  logic                     Reset,
  input  logic                     start,
  input  mul_pkg::mul_op_t         op,
  input  logic [mul_pkg::XLEN-1:0] a,
  input  logic [mul_pkg::XLEN-1:0] b,
  input  logic [mul_pkg::RD_W-1:0] rd,
  output logic                     done,
  output logic [mul_pkg::RD_W-1:0] rd_out,
  output logic [mul_pkg::XLEN-1:0] result
);

  mul_stage_if #(.payload_t(mul_pkg::enc_payload_t))  enc_if ();
  mul_stage_if #(.payload_t(mul_pkg::pp_payload_t))   pp_if ();
  mul_stage_if #(.payload_t(mul_pkg::red2_payload_t)) r2_if ();

  booth_encoder u_booth_encoder (
    .Clk    (Clk),
    .Reset  (Reset),
    .start  (start),
    .op     (op),
    .a      (a),
    .b      (b),
    .rd     (rd),
    .out_if (enc_if)
  );

  pp_generator u_pp_generator (
    .Clk    (Clk),
    .Reset  (Reset),
    .in_if  (enc_if),
    .out_if (pp_if)
  );

  // stages three to five
  reduction_tree u_reduction_tree (
    .Clk    (Clk),
    .Reset  (Reset),
    .in_if  (pp_if),
    .out_if (r2_if)
  );

  final_adder u_final_adder (
    .Clk    (Clk),
    .Reset  (Reset),
    .in_if  (r2_if),
    .done   (done),
    .rd_out (rd_out),
    .result (result)
  );

endmodule

// File: verification/clk_gen.sv
module clk_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic Clk,
  output logic Reset
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    Clk = 1'b0;
    forever #(PERIOD / 2) Clk = ~Clk;
  end

  // deassert right at a rising edge so the first live edge follows cleanly
  initial begin
    Reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge Clk);
    Reset <= 1'b0;
  end

endmodule

// File: verification/tb_booth_mul.sv
module tb_booth_mul;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD       = 10;
  localparam int RESET_CYCLES = 8;
  localparam int N_ITEMS      = 400;
  // first items sweep every op over all corner operand pairs
  localparam int N_GRID       = 75;
  // issue rate is about 3/4, so allow twice the item count
  localparam int TIMEOUT_CYCLES = 2 * N_ITEMS + mul_pkg::LATENCY + RESET_CYCLES + 20;

  typedef struct packed {
    logic [mul_pkg::XLEN-1:0] res;
    logic [mul_pkg::RD_W-1:0] rd;
    int                       cycle;
  } expect_t;

  logic                     Clk;
  logic                     Reset;
  logic                     start;
  mul_pkg::mul_op_t         op;
  logic [mul_pkg::XLEN-1:0] a;
  logic [mul_pkg::XLEN-1:0] b;
  logic [mul_pkg::RD_W-1:0] rd;
  logic                     done;
  logic [mul_pkg::RD_W-1:0] rd_out;
  logic [mul_pkg::XLEN-1:0] result;

  int                       seed = 32'h4ef5_0142;
  int                       cycle;
  int                       issued;
  int                       checked;
  int                       errors;
  expect_t                  exp_q[$];
  logic [mul_pkg::XLEN-1:0] last_result;
  logic [mul_pkg::RD_W-1:0] last_rd;

  clk_gen #(
    .PERIOD       (PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) clk_gen_inst (
    .Clk   (Clk),
    .Reset (Reset)
  );

  booth_mul booth_mul_inst (
    .Clk    (Clk),
    .Reset  (Reset),
    .start  (start),
    .op     (op),
    .a      (a),
    .b      (b),
    .rd     (rd),
    .done   (done),
    .rd_out (rd_out),
    .result (result)
  );

  function automatic logic [mul_pkg::XLEN-1:0] corner_value(int idx);
    case (idx)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      3:       return 32'h8000_0000;
      default: return 32'h7fff_ffff;
    endcase
  endfunction

  function automatic mul_pkg::mul_op_t op_from_index(int k);
    case (k)
      0:       return mul_pkg::OP_MUL;
      1:       return mul_pkg::OP_MULH;
      default: return mul_pkg::OP_MULHU;
    endcase
  endfunction

  // one operand in four is a corner value
  function automatic logic [mul_pkg::XLEN-1:0] pick_operand();
    int r;
    r = {$random(seed)} % 20;
    if (r < 5) begin
      return corner_value(r);
    end
    return $random(seed);
  endfunction

  // full 64-bit product, signed for mul and mulh, unsigned for mulhu
  function automatic logic [mul_pkg::XLEN-1:0] expected_result(mul_pkg::mul_op_t f_op,
                                                               logic [mul_pkg::XLEN-1:0] x,
                                                               logic [mul_pkg::XLEN-1:0] y);
    logic [63:0] xe;
    logic [63:0] ye;
    logic [63:0] prod;
    if (f_op == mul_pkg::OP_MULHU) begin
      xe = {32'h0, x};
      ye = {32'h0, y};
    end else begin
      xe = {{32{x[31]}}, x};
      ye = {{32{y[31]}}, y};
    end
    prod = xe * ye;
    return (f_op == mul_pkg::OP_MUL) ? prod[31:0] : prod[63:32];
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
    errors++;
    $display("ERROR %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
  endtask

  task automatic report_failure(string msg);
    errors++;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  task automatic check_reset_state();
    assert (done === 1'b0) else report_mismatch("done", 32'(done), 0);
    assert (result === '0) else report_mismatch("result", result, 0);
    assert (rd_out === '0) else report_mismatch("rd_out", 32'(rd_out), 0);
  endtask

  task automatic check_outputs();
    expect_t head;
    if (done) begin
      assert (exp_q.size() > 0) else report_failure("done pulsed with no item outstanding");
      if (exp_q.size() > 0) begin
        head = exp_q.pop_front();
        assert (cycle - head.cycle == mul_pkg::LATENCY)
          else report_mismatch("latency", cycle - head.cycle, mul_pkg::LATENCY);
        assert (result === head.res) else report_mismatch("result", result, head.res);
        assert (rd_out === head.rd) else report_mismatch("rd_out", 32'(rd_out), 32'(head.rd));
        checked++;
      end
      last_result = result;
      last_rd     = rd_out;
    end else begin
      // outputs hold between done pulses
      assert (result === last_result) else report_mismatch("result", result, last_result);
      assert (rd_out === last_rd) else report_mismatch("rd_out", 32'(rd_out), 32'(last_rd));
      if (exp_q.size() > 0) begin
        assert (exp_q[0].cycle + mul_pkg::LATENCY != cycle)
          else report_failure("done missing for an item that was due");
      end
    end
  endtask

  task automatic drive_next();
    expect_t item;
    if (issued < N_ITEMS && ({$random(seed)} % 4) != 0) begin
      if (issued < N_GRID) begin
        op = op_from_index(issued / 25);
        a  = corner_value(issued % 5);
        b  = corner_value((issued / 5) % 5);
      end else begin
        op = op_from_index({$random(seed)} % 3);
        a  = pick_operand();
        b  = pick_operand();
      end
      rd         = issued[mul_pkg::RD_W-1:0];
      start      = 1'b1;
      item.res   = expected_result(op, a, b);
      item.rd    = rd;
      item.cycle = cycle;
      exp_q.push_back(item);
      issued++;
    end else begin
      start = 1'b0;
    end
  endtask

  initial begin
    start       = 1'b0;
    op          = mul_pkg::OP_MUL;
    a           = '0;
    b           = '0;
    rd          = '0;
    cycle       = 0;
    issued      = 0;
    checked     = 0;
    errors      = 0;
    last_result = '0;
    last_rd     = '0;

    @(negedge Clk);
    while (Reset) begin
      check_reset_state();
      @(negedge Clk);
    end

    // outputs are sampled before new inputs go out on each falling edge
    while (issued < N_ITEMS) begin
      cycle++;
      check_outputs();
      drive_next();
      @(negedge Clk);
    end

    // drain the pipeline, then nothing more may come out
    repeat (mul_pkg::LATENCY + 2) begin
      cycle++;
      check_outputs();
      drive_next();
      @(negedge Clk);
    end

    assert (exp_q.size() == 0) else report_failure("items left in the model queue");
    $display("issued %0d, checked %0d, errors %0d", issued, checked, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * PERIOD);
    $display("ERROR %0t: timeout with %0d of %0d items checked", $time, checked, N_ITEMS);
    $display("sim failed");
    $finish;
  end

endmodule

// File: sim.f
rtl/mul_pkg.sv
rtl/mul_stage_if.sv
rtl/mul_stage_reg.sv
rtl/csa_reduce.sv
rtl/booth_encoder.sv
rtl/pp_generator.sv
rtl/reduction_tree.sv
rtl/final_adder.sv
rtl/booth_mul.sv
verification/clk_gen.sv
verification/tb_booth_mul.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/100ps
TOP        = tb_booth_mul
FILELIST   = sim.f
OBJ_DIR    = obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
